//--- hw/cache_config.svh
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// data word and cpu word address
`define CACHE_WORD_W 16
`define CACHE_ADDR_W 10

// eight words per line
`define CACHE_OFFSET_W 3

// index widths of the two caches
`define CACHE_IC_INDEX_W 4
`define CACHE_DC_INDEX_W 5

// main memory block number, 7 bits
`define CACHE_BLK_W (`CACHE_ADDR_W - `CACHE_OFFSET_W)

// whole line, word 0 in the low bits
`define CACHE_LINE_W (`CACHE_WORD_W * (1 << `CACHE_OFFSET_W))

// number of lines held by main memory
`define CACHE_MEM_DEPTH (1 << `CACHE_BLK_W)

`endif

//--- hw/cache_pkg.sv
`default_nettype none
`include "cache_config.svh"

package cache_pkg;

	typedef logic [`CACHE_WORD_W-1:0] word_t;
	typedef logic [`CACHE_ADDR_W-1:0] addr_t;
	typedef logic [`CACHE_BLK_W-1:0]  blk_addr_t;
	typedef logic [`CACHE_LINE_W-1:0] line_t;

	// request from a cpu port, 27 bits
	typedef struct packed {
		addr_t addr;
		logic  we;
		word_t wdata;
	} cpu_req_t;

	// line access toward main memory, 136 bits
	typedef struct packed {
		blk_addr_t blk;
		logic      we;
		line_t     data;  // victim line on writeback
	} mem_req_t;

	typedef enum logic [2:0] {
		IDLE,
		LOOKUP,
		WRITEBACK,
		REFILL,
		RESPOND
	} ctrl_state_t;

endpackage

`default_nettype wire

//--- hw/cache_ctrl.sv
`timescale 1ns/1ns
`default_nettype none
`include "cache_config.svh"

// direct-mapped write-back cache, one request in flight
module cache_ctrl
	import cache_pkg::*;
#(
	parameter int INDEX_W = 4
) (
	input  logic     clk,
	input  logic     rst_n,
	input  cpu_req_t req,
	input  logic     req_valid,
	output logic     req_ready,
	output logic     resp_valid,
	output word_t    rdata,
	output mem_req_t mem_req,
	output logic     mem_valid,
	input  logic     mem_ack,
	input  line_t    mem_rdata
);

	localparam int TAG_W = `CACHE_ADDR_W - `CACHE_OFFSET_W - INDEX_W;
	localparam int LINES = 1 << INDEX_W;

	typedef logic [INDEX_W-1:0]         index_t;
	typedef logic [TAG_W-1:0]           tag_t;
	typedef logic [`CACHE_OFFSET_W-1:0] offset_t;

	ctrl_state_t state;
	cpu_req_t    req_q;   // accepted request
	word_t       rdata_q;

	line_t            data_arr [LINES];
	tag_t             tag_arr [LINES];
	logic [LINES-1:0] valid_bits;
	logic [LINES-1:0] dirty_bits;

	index_t  idx;
	tag_t    tag;
	offset_t off;
	logic    hit;
	line_t   src_line;
	line_t   new_line;

	// replace one word of a line
	function automatic line_t merge_word(line_t line, offset_t sel, word_t w);
		line_t merged;
		merged = line;
		merged[sel*`CACHE_WORD_W +: `CACHE_WORD_W] = w;
		return merged;
	endfunction

	assign idx = req_q.addr[`CACHE_OFFSET_W +: INDEX_W];
	assign tag = req_q.addr[`CACHE_ADDR_W-1 -: TAG_W];
	assign off = req_q.addr[`CACHE_OFFSET_W-1:0];
	assign hit = valid_bits[idx] && (tag_arr[idx] == tag);

	// refill data comes straight from memory, hits from the array
	assign src_line = (state == REFILL) ? mem_rdata : data_arr[idx];
	assign new_line = req_q.we ? merge_word(src_line, off, req_q.wdata) : src_line;

	assign req_ready  = (state == IDLE);
	assign resp_valid = (state == RESPOND);
	assign rdata      = rdata_q;
	assign mem_valid  = (state == WRITEBACK) || (state == REFILL);

	always_comb begin
		mem_req.blk  = req_q.addr[`CACHE_ADDR_W-1:`CACHE_OFFSET_W];
		mem_req.we   = 1'b0;
		mem_req.data = data_arr[idx];
		if (state == WRITEBACK) begin
			mem_req.blk = {tag_arr[idx], idx};  // victim block
			mem_req.we  = 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= IDLE;
			valid_bits <= '0;
			dirty_bits <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (req_valid)
						state <= LOOKUP;
				end
				LOOKUP: begin
					if (hit) begin
						state <= RESPOND;
						if (req_q.we)
							dirty_bits[idx] <= 1'b1;
					end else if (valid_bits[idx] && dirty_bits[idx]) begin
						state <= WRITEBACK;
					end else begin
						state <= REFILL;
					end
				end
				WRITEBACK: begin
					if (mem_ack)
						state <= REFILL;
				end
				REFILL: begin
					if (mem_ack) begin
						state           <= RESPOND;
						valid_bits[idx] <= 1'b1;
						dirty_bits[idx] <= req_q.we;  // clean after a read refill
					end
				end
				RESPOND: state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	// arrays and request payload
	always_ff @(posedge clk) begin
		if (state == IDLE && req_valid)
			req_q <= req;
		if (state == LOOKUP && hit) begin
			if (req_q.we)
				data_arr[idx] <= new_line;
			rdata_q <= new_line[off*`CACHE_WORD_W +: `CACHE_WORD_W];
		end
		if (state == REFILL && mem_ack) begin
			data_arr[idx] <= new_line;
			tag_arr[idx]  <= tag;
			rdata_q       <= new_line[off*`CACHE_WORD_W +: `CACHE_WORD_W];
		end
	end

endmodule

`default_nettype wire

//--- hw/mem_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

// one cache owns main memory until its ack
module mem_arbiter
	import cache_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  mem_req_t ic_mem_req,
	input  mem_req_t dc_mem_req,
	input  logic     ic_mem_valid,
	input  logic     dc_mem_valid,
	output logic     ic_mem_ack,
	output logic     dc_mem_ack,
	output mem_req_t mem_req,
	output logic     mem_valid,
	input  logic     mem_ack
);

	logic busy;      // grant held
	logic owner_dc;  // 1 = data cache owns memory
	logic last_dc;   // data cache served last
	logic pick_dc;

	// data first, but a waiting instruction request gets the next turn
	assign pick_dc = dc_mem_valid && (!ic_mem_valid || !last_dc);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy     <= 1'b0;
			owner_dc <= 1'b0;
			last_dc  <= 1'b0;
		end else if (busy) begin
			if (mem_ack)
				busy <= 1'b0;
		end else if (ic_mem_valid || dc_mem_valid) begin
			busy     <= 1'b1;
			owner_dc <= pick_dc;
			last_dc  <= pick_dc;
		end
	end

	assign mem_req   = owner_dc ? dc_mem_req : ic_mem_req;
	assign mem_valid = busy && (owner_dc ? dc_mem_valid : ic_mem_valid);

	// ack goes back to the owner only
	assign ic_mem_ack = busy && !owner_dc && mem_ack;
	assign dc_mem_ack = busy && owner_dc && mem_ack;

endmodule

`default_nettype wire

//--- hw/main_memory.sv
`timescale 1ns/1ns
`default_nettype none
`include "cache_config.svh"

// line-wide backing store
module main_memory
	import cache_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  mem_req_t mem_req,
	input  logic     mem_valid,
	output logic     mem_ack,
	output line_t    mem_rdata
);

	line_t mem [`CACHE_MEM_DEPTH];
	logic  start;

	// a request still high during its own ack is not taken again
	assign start = mem_valid && !mem_ack;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			mem_ack <= 1'b0;
		else
			mem_ack <= start;
	end

	always_ff @(posedge clk) begin
		if (start) begin
			if (mem_req.we)
				mem[mem_req.blk] <= mem_req.data;
			else
				mem_rdata <= mem[mem_req.blk];  // valid with the ack
		end
	end

endmodule

`default_nettype wire

//--- hw/cache_top.sv
`timescale 1ns/1ns
`default_nettype none
`include "cache_config.svh"

module cache_top
	import cache_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  cpu_req_t ic_req,
	input  logic     ic_req_valid,
	output logic     ic_req_ready,
	output logic     ic_resp_valid,
	output word_t    ic_rdata,
	input  cpu_req_t dc_req,
	input  logic     dc_req_valid,
	output logic     dc_req_ready,
	output logic     dc_resp_valid,
	output word_t    dc_rdata
);

	mem_req_t ic_mem_req;
	mem_req_t dc_mem_req;
	mem_req_t mem_req;
	logic     ic_mem_valid;
	logic     dc_mem_valid;
	logic     mem_valid;
	logic     ic_mem_ack;
	logic     dc_mem_ack;
	logic     mem_ack;
	line_t    mem_rdata;  // seen by both caches

	cache_ctrl #(
		.INDEX_W(`CACHE_IC_INDEX_W)
	) u_icache (
		.clk       (clk),
		.rst_n     (rst_n),
		.req       (ic_req),
		.req_valid (ic_req_valid),
		.req_ready (ic_req_ready),
		.resp_valid(ic_resp_valid),
		.rdata     (ic_rdata),
		.mem_req   (ic_mem_req),
		.mem_valid (ic_mem_valid),
		.mem_ack   (ic_mem_ack),
		.mem_rdata (mem_rdata)
	);

	cache_ctrl #(
		.INDEX_W(`CACHE_DC_INDEX_W)
	) u_dcache (
		.clk       (clk),
		.rst_n     (rst_n),
		.req       (dc_req),
		.req_valid (dc_req_valid),
		.req_ready (dc_req_ready),
		.resp_valid(dc_resp_valid),
		.rdata     (dc_rdata),
		.mem_req   (dc_mem_req),
		.mem_valid (dc_mem_valid),
		.mem_ack   (dc_mem_ack),
		.mem_rdata (mem_rdata)
	);

	mem_arbiter u_arb (
		.clk         (clk),
		.rst_n       (rst_n),
		.ic_mem_req  (ic_mem_req),
		.dc_mem_req  (dc_mem_req),
		.ic_mem_valid(ic_mem_valid),
		.dc_mem_valid(dc_mem_valid),
		.ic_mem_ack  (ic_mem_ack),
		.dc_mem_ack  (dc_mem_ack),
		.mem_req     (mem_req),
		.mem_valid   (mem_valid),
		.mem_ack     (mem_ack)
	);

	main_memory u_mem (
		.clk      (clk),
		.rst_n    (rst_n),
		.mem_req  (mem_req),
		.mem_valid(mem_valid),
		.mem_ack  (mem_ack),
		.mem_rdata(mem_rdata)
	);

endmodule

`default_nettype wire

//--- sim/cache_checker.sv
`timescale 1ns/1ns
`default_nettype none

// handshake and arbitration properties of cache_top
module cache_checker
	import cache_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic ic_req_valid,
	input logic ic_req_ready,
	input logic ic_resp_valid,
	input logic dc_req_valid,
	input logic dc_req_ready,
	input logic dc_resp_valid,
	input logic ic_mem_ack,
	input logic dc_mem_ack
);

	int failures = 0;  // failed property count

	// controller leaves IDLE on accept
	ic_busy_after_accept: assert property (@(posedge clk) disable iff (!rst_n)
		ic_req_valid && ic_req_ready |=> !ic_req_ready)
		else begin
			failures++;
			$error("ic req_ready high in the cycle after an accept");
		end
	dc_busy_after_accept: assert property (@(posedge clk) disable iff (!rst_n)
		dc_req_valid && dc_req_ready |=> !dc_req_ready)
		else begin
			failures++;
			$error("dc req_ready high in the cycle after an accept");
		end

	ic_resp_strobe: assert property (@(posedge clk) disable iff (!rst_n)
		ic_resp_valid |=> !ic_resp_valid)
		else begin
			failures++;
			$error("ic resp_valid high on two cycles in a row");
		end
	dc_resp_strobe: assert property (@(posedge clk) disable iff (!rst_n)
		dc_resp_valid |=> !dc_resp_valid)
		else begin
			failures++;
			$error("dc resp_valid high on two cycles in a row");
		end

	one_ack: assert property (@(posedge clk) disable iff (!rst_n)
		!(ic_mem_ack && dc_mem_ack))
		else begin
			failures++;
			$error("memory ack sent to both caches at once");
		end

endmodule

bind cache_top cache_checker u_checker (
	.clk          (clk),
	.rst_n        (rst_n),
	.ic_req_valid (ic_req_valid),
	.ic_req_ready (ic_req_ready),
	.ic_resp_valid(ic_resp_valid),
	.dc_req_valid (dc_req_valid),
	.dc_req_ready (dc_req_ready),
	.dc_resp_valid(dc_resp_valid),
	.ic_mem_ack   (ic_mem_ack),
	.dc_mem_ack   (dc_mem_ack)
);

`default_nettype wire

//--- sim/cache_tb.sv
`timescale 1ns/1ns
`default_nettype none

module cache_tb
	import cache_pkg::*;
();

	localparam int MAX_REC = 64;

	// one record of the pattern file
	typedef struct packed {
		logic [2:0] port_pad;
		logic       dc;        // 0 = instruction port
		logic [2:0] we_pad;
		logic       we;
		logic [1:0] addr_pad;
		addr_t      addr;
		word_t      wdata;
		logic [2:0] chk_pad;
		logic       chk;
		word_t      exp_word;
	} pattern_t;

	logic       clk;
	logic       rst_n;
	cpu_req_t   req [2];    // index 0 = ic, 1 = dc
	logic [1:0] req_valid;
	logic [1:0] req_ready;
	logic [1:0] resp_valid;
	word_t      rdata [2];

	logic [55:0] raw [MAX_REC];
	int          nrec;
	logic        loaded = 1'b0;
	integer      seed;
	int          errors = 0;
	int          checks = 0;
	int          sent [2] = '{0, 0};
	int          seen [2] = '{0, 0};

	cache_top UUT (
		.clk          (clk),
		.rst_n        (rst_n),
		.ic_req       (req[0]),
		.ic_req_valid (req_valid[0]),
		.ic_req_ready (req_ready[0]),
		.ic_resp_valid(resp_valid[0]),
		.ic_rdata     (rdata[0]),
		.dc_req       (req[1]),
		.dc_req_valid (req_valid[1]),
		.dc_req_ready (req_ready[1]),
		.dc_resp_valid(resp_valid[1]),
		.dc_rdata     (rdata[1])
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic check_word(input string name, input word_t actual, input word_t expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Error at %0t ns: %s = %h, expected %h", $time, name, actual, expected);
		end
	endtask

	task automatic check_flag(input string name, input logic actual, input logic expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Error at %0t ns: %s = %b, expected %b", $time, name, actual, expected);
		end
	endtask

	task automatic check_count(input string name, input int actual, input int expected);
		checks++;
		if (actual != expected) begin
			errors++;
			$display("Error at %0t ns: %s = %0d, expected %0d", $time, name, actual, expected);
		end
	endtask

	// walk the records of one port in file order
	task automatic run_port(input int port);
		pattern_t p;
		string    pname;
		int       gap;
		int       i;
		pname = (port == 1) ? "dc" : "ic";
		for (i = 0; i < nrec; i++) begin
			p = pattern_t'(raw[i]);
			if (int'(p.dc) == port) begin
				gap = {$random(seed)} % 4;
				repeat (gap) @(negedge clk);
				req[port]       = '{addr: p.addr, we: p.we, wdata: p.wdata};
				req_valid[port] = 1'b1;
				while (!req_ready[port])
					@(negedge clk);
				@(negedge clk);  // taken on the edge before
				req_valid[port] = 1'b0;
				sent[port]++;
				while (!resp_valid[port])
					@(negedge clk);
				if (p.chk)
					check_word({pname, "_rdata"}, rdata[port], p.exp_word);
			end
		end
	endtask

	// response strobes per port
	always @(negedge clk) begin
		if (resp_valid[0])
			seen[0]++;
		if (resp_valid[1])
			seen[1]++;
	end

	initial begin
		int i;
		rst_n     = 1'b0;
		req_valid = '0;
		req[0]    = '0;
		req[1]    = '0;
		seed      = 32'h4165a189;
		nrec      = 0;
		for (i = 0; i < MAX_REC; i++)
			raw[i] = '1;  // all ones marks an unused slot
		$readmemh("sim/cache_patterns.txt", raw);
		while (nrec < MAX_REC && raw[nrec] !== '1)
			nrec++;
		if (nrec == 0) begin
			$display("no stimulus records were read from sim/cache_patterns.txt");
			errors++;
		end
		loaded = 1'b1;

		repeat (3) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		check_flag("ic_req_ready", req_ready[0], 1'b1);
		check_flag("dc_req_ready", req_ready[1], 1'b1);
		check_flag("ic_resp_valid", resp_valid[0], 1'b0);
		check_flag("dc_resp_valid", resp_valid[1], 1'b0);

		fork
			run_port(0);
			run_port(1);
		join

		repeat (3) @(negedge clk);
		check_count("ic responses", seen[0], sent[0]);
		check_count("dc responses", seen[1], sent[1]);
		errors += UUT.u_checker.failures;  // failed properties of the bound checker

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

	// run limit scales with the number of records
	initial begin
		wait (loaded);
		#(nrec * 40 * 10);
		$display("timeout after %0d ns with requests still pending", nrec * 40 * 10);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim/cache_patterns.txt
// fields port we addr wdata chk expected as one hex word
// port 0 is the instruction side and chk 1 compares rdata with expected
0_1_010_1111_1_1111
0_1_013_1333_1_1333
0_0_010_0000_1_1111
0_1_090_2222_1_2222
0_0_013_0000_1_1333
0_0_010_0000_1_1111
0_0_090_0000_1_2222
0_1_1a5_3a5a_1_3a5a
0_1_010_1010_1_1010
0_0_010_0000_1_1010
0_0_013_0000_1_1333
0_0_1a5_0000_1_3a5a
1_1_200_a000_1_a000
1_1_207_a007_1_a007
1_1_300_b000_1_b000
1_0_207_0000_1_a007
1_0_200_0000_1_a000
1_0_300_0000_1_b000
1_1_3f8_cafe_1_cafe
1_1_2f8_beef_1_beef
1_0_3f8_0000_1_cafe
1_0_2f8_0000_1_beef

//--- flist.f
+incdir+hw
hw/cache_pkg.sv
hw/cache_ctrl.sv
hw/mem_arbiter.sv
hw/main_memory.sv
hw/cache_top.sv
sim/cache_checker.sv
sim/cache_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ns \
	-f flist.f --top-module cache_tb -o cache_sim &&
./obj_dir/cache_sim | awk '{ print } /^NO ERRORS$/ { ok = 1 } END { exit !ok }' &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
